// File: source/aib_rate_pkg.sv
package aib_rate_pkg;

   // ------------------------------
   // Rate encodings
   // ------------------------------
   typedef logic [3:0] rate_t;                          // 1 full, 2 half, 4 quarter

   localparam rate_t RATE_FULL    = 4'h1;
   localparam rate_t RATE_HALF    = 4'h2;
   localparam rate_t RATE_QUARTER = 4'h4;

   localparam rate_t LEADER_RATE   = RATE_FULL;         // This side
   localparam rate_t FOLLOWER_RATE = RATE_HALF;         // Far side of the link

   // ------------------------------
   // Marker and strobe spacing
   // ------------------------------
   localparam int WORDS_PER_MARKER = FOLLOWER_RATE / LEADER_RATE; // Leader words per follower word
   localparam int TX_STB_INTV      = 24;                // Strobe period in markers
   localparam int STB_INTV_WORDS   = TX_STB_INTV * WORDS_PER_MARKER; // Same period in words

   // ------------------------------
   // Alignment delays
   // ------------------------------
   typedef logic [15:0] delay_t;                        // Delay count in cycles

   localparam int DELAY_IN_W = 32;                      // Width of the delay input ports

endpackage

// File: source/ca_word_pkg.sv
package ca_word_pkg;

   // ------------------------------
   // Channel geometry
   // ------------------------------
   localparam int NUM_CHANNELS = 7;                     // Lanes toward the PHY
   localparam int LANE_BITS    = 40;                    // One leader word per lane

   localparam int MARKER_LOC = 39;                      // Marker bit position
   localparam int STROBE_LOC = 1;                       // Strobe bit position

   // ------------------------------
   // Lane word views
   // ------------------------------
   // Field view used when marker and strobe get inserted
   typedef struct packed {
      logic                                  marker;   // Bit 39
      logic [MARKER_LOC-STROBE_LOC-2:0]      payload;  // Bits 38..2
      logic                                  strobe;   // Bit 1
      logic                                  push;     // Bit 0
   } lane_fields_t;

   // Same 40 bits, raw from the link layer or split into fields
   typedef union packed {
      logic [LANE_BITS-1:0] raw;                        // Link layer view
      lane_fields_t         fields;                     // Framing view
   } lane_word_t;

   typedef lane_word_t [NUM_CHANNELS-1:0] lane_bus_t;   // All lanes of one cycle

   typedef logic [NUM_CHANNELS-1:0] chan_mask_t;        // One bit per channel

endpackage

// File: source/align_timer.sv
`timescale 1ns/10ps

module align_timer
   import aib_rate_pkg::*, ca_word_pkg::*;
(
   input  logic                  i_m_wr_clk,
   input  logic                  i_m_wr_rst_n,
   input  logic [DELAY_IN_W-1:0] i_delay_x_value,       // Word alignment time
   input  logic [DELAY_IN_W-1:0] i_delay_z_value,       // AIB alignment time
   input  chan_mask_t            i_sl_tx_transfer_en,
   input  chan_mask_t            i_ms_tx_transfer_en,
   output logic                  o_tx_transfer_en,
   output logic                  o_align_done
);

   localparam int DLY_W = $bits(delay_t);
   localparam int SUM_W = DLY_W + 1;                    // Room for x plus z

   delay_t             delay_x_reg1;                    // First sync stage
   delay_t             delay_x_reg2;                    // Second sync stage
   delay_t             delay_z_reg1;
   delay_t             delay_z_reg2;
   delay_t             delay_x_scaled;                  // In leader cycles
   delay_t             delay_z_scaled;
   logic [SUM_W-1:0]   align_target;                    // Total wait
   logic [SUM_W-1:0]   wait_cnt;
   logic               cnt_hit;

   // ------------------------------
   // Delay registers and scaling
   // ------------------------------
   always_ff @(posedge i_m_wr_clk)
   begin
      if (!i_m_wr_rst_n)
      begin
         delay_x_reg1 <= '0;
         delay_x_reg2 <= '0;
         delay_z_reg1 <= '0;
         delay_z_reg2 <= '0;
      end
      else
      begin
         delay_x_reg1 <= i_delay_x_value[DLY_W-1:0];    // Upper half ignored
         delay_x_reg2 <= delay_x_reg1;
         delay_z_reg1 <= i_delay_z_value[DLY_W-1:0];
         delay_z_reg2 <= delay_z_reg1;
      end
   end

   assign delay_x_scaled = delay_x_reg2 / LEADER_RATE;
   assign delay_z_scaled = delay_z_reg2 / LEADER_RATE;
   assign align_target   = {1'b0, delay_x_scaled} + {1'b0, delay_z_scaled};

   // All 14 lanes ready in both directions
   assign o_tx_transfer_en = (&i_sl_tx_transfer_en) & (&i_ms_tx_transfer_en);

   // ------------------------------
   // Alignment wait
   // ------------------------------
   assign cnt_hit = (wait_cnt >= align_target);         // Also covers a shrinking target

   always_ff @(posedge i_m_wr_clk)
   begin
      if (!i_m_wr_rst_n)
      begin
         wait_cnt     <= '0;
         o_align_done <= 1'b0;
      end
      else if (!o_tx_transfer_en)
      begin
         wait_cnt     <= '0;                            // Restart on any lane drop
         o_align_done <= 1'b0;
      end
      else
      begin
         if (!cnt_hit)
            wait_cnt <= wait_cnt + 1'b1;                // Parks once target reached
         if (cnt_hit)
            o_align_done <= 1'b1;                       // Sticky until enable falls
      end
   end

endmodule

// File: source/marker_strobe_gen.sv
`timescale 1ns/10ps

module marker_strobe_gen
   import aib_rate_pkg::*;
(
   input  logic i_m_wr_clk,
   input  logic i_m_wr_rst_n,
   output logic o_marker,                               // Last leader word of a follower word
   output logic o_strobe                                // Every TX_STB_INTV-th marker
);

   // Keep at least one bit when rates match
   localparam int WORD_CNT_W = (WORDS_PER_MARKER > 1) ? $clog2(WORDS_PER_MARKER) : 1;
   localparam int MARK_CNT_W = (TX_STB_INTV > 1) ? $clog2(TX_STB_INTV) : 1;

   localparam logic [WORD_CNT_W-1:0] WORD_LAST = WORD_CNT_W'(WORDS_PER_MARKER - 1);
   localparam logic [MARK_CNT_W-1:0] MARK_LAST = MARK_CNT_W'(TX_STB_INTV - 1);

   logic [WORD_CNT_W-1:0] word_cnt;                     // Position inside follower word
   logic [MARK_CNT_W-1:0] mark_cnt;                     // Markers since last strobe
   logic                  word_last;
   logic                  mark_last;

   // ------------------------------
   // Word counter
   // ------------------------------
   assign word_last = (word_cnt == WORD_LAST);

   always_ff @(posedge i_m_wr_clk)
   begin
      if (!i_m_wr_rst_n)
         word_cnt <= '0;                                // Index 0 right after reset
      else if (word_last)
         word_cnt <= '0;                                // Wrap
      else
         word_cnt <= word_cnt + 1'b1;
   end

   // ------------------------------
   // Marker counter
   // ------------------------------
   assign mark_last = (mark_cnt == MARK_LAST);

   always_ff @(posedge i_m_wr_clk)
   begin
      if (!i_m_wr_rst_n)
         mark_cnt <= '0;
      else if (word_last)
      begin
         if (mark_last)
            mark_cnt <= '0;                             // Strobe period done
         else
            mark_cnt <= mark_cnt + 1'b1;                // One more marker sent
      end
   end

   // Strobe rides only on a marker word
   assign o_marker = word_last;
   assign o_strobe = word_last & mark_last;

endmodule

// File: source/ca_tx_framer.sv
`timescale 1ns/10ps

module ca_tx_framer
   import ca_word_pkg::*;
(
   input  logic      i_m_wr_clk,
   input  logic      i_m_wr_rst_n,
   input  logic      i_align_done,                      // Link is aligned
   input  logic      i_marker,
   input  logic      i_strobe,
   input  lane_bus_t i_ll2ca,                           // From the link layer
   output lane_bus_t o_ca2phy                           // Toward the PHY
);

   lane_bus_t framed;                                   // Lanes with marker and strobe

   // ------------------------------
   // Marker and strobe insertion
   // ------------------------------
   always_comb
   begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++)
      begin
         framed[ch].raw           = i_ll2ca[ch].raw;    // Take the word as is
         framed[ch].fields.marker = i_marker;           // Then patch bit 39
         framed[ch].fields.strobe = i_strobe;           // And bit 1
      end
   end

   // ------------------------------
   // Output register
   // ------------------------------
   // One cycle through, quiet lanes until alignment is done
   always_ff @(posedge i_m_wr_clk)
   begin
      if (!i_m_wr_rst_n)
         o_ca2phy <= '0;
      else if (i_align_done)
         o_ca2phy <= framed;
      else
         o_ca2phy <= '0;                                // Idle lanes
   end

endmodule

// File: source/aib_leader_ca_top.sv
`timescale 1ns/10ps

module aib_leader_ca_top
   import aib_rate_pkg::*, ca_word_pkg::*;
(
   input  logic                  m_wr_clk,
   input  logic                  m_wr_rst_n,            // Sync, active low
   input  logic [DELAY_IN_W-1:0] i_delay_x_value,
   input  logic [DELAY_IN_W-1:0] i_delay_z_value,
   input  chan_mask_t            i_sl_tx_transfer_en,   // Follower to leader lanes
   input  chan_mask_t            i_ms_tx_transfer_en,   // Leader to follower lanes
   input  lane_bus_t             i_ll2ca,
   output lane_bus_t             o_ca2phy,
   output logic                  o_tx_transfer_en,
   output logic                  o_align_done
);

   logic marker;                                        // Per word marker bit
   logic strobe;                                        // Per word strobe bit

   // ------------------------------
   // Alignment state
   // ------------------------------
   align_timer align_timer_inst
   (
      .i_m_wr_clk          (m_wr_clk),
      .i_m_wr_rst_n        (m_wr_rst_n),
      .i_delay_x_value     (i_delay_x_value),
      .i_delay_z_value     (i_delay_z_value),
      .i_sl_tx_transfer_en (i_sl_tx_transfer_en),
      .i_ms_tx_transfer_en (i_ms_tx_transfer_en),
      .o_tx_transfer_en    (o_tx_transfer_en),          // Straight to the pin
      .o_align_done        (o_align_done)               // Pin and framer gate
   );

   // ------------------------------
   // Marker and strobe timing
   // ------------------------------
   // Free running from reset release, independent of alignment
   marker_strobe_gen marker_strobe_gen_inst
   (
      .i_m_wr_clk   (m_wr_clk),
      .i_m_wr_rst_n (m_wr_rst_n),
      .o_marker     (marker),
      .o_strobe     (strobe)
   );

   // ------------------------------
   // Outgoing lanes
   // ------------------------------
   ca_tx_framer ca_tx_framer_inst
   (
      .i_m_wr_clk   (m_wr_clk),
      .i_m_wr_rst_n (m_wr_rst_n),
      .i_align_done (o_align_done),
      .i_marker     (marker),
      .i_strobe     (strobe),
      .i_ll2ca      (i_ll2ca),
      .o_ca2phy     (o_ca2phy)                          // One cycle behind i_ll2ca
   );

endmodule

// File: tests/aib_leader_ca_tb.sv
`timescale 1ns/10ps

module aib_leader_ca_tb
   import aib_rate_pkg::*, ca_word_pkg::*;
();

   logic                  m_wr_clk;
   logic                  m_wr_rst_n;
   logic [DELAY_IN_W-1:0] i_delay_x_value;
   logic [DELAY_IN_W-1:0] i_delay_z_value;
   chan_mask_t            i_sl_tx_transfer_en;
   chan_mask_t            i_ms_tx_transfer_en;
   lane_bus_t             i_ll2ca;
   lane_bus_t             o_ca2phy;
   logic                  o_tx_transfer_en;
   logic                  o_align_done;

   logic [DELAY_IN_W-1:0] tbl_x[$];                     // Stimulus table columns
   logic [DELAY_IN_W-1:0] tbl_z[$];
   chan_mask_t            tbl_sl[$];
   chan_mask_t            tbl_ms[$];
   int                    tbl_len[$];                   // Run length in cycles

   logic [31:0] lfsr_state = 32'h76d9_e395;
   lane_bus_t   next_lanes;
   lane_bus_t   prev_ll2ca;                             // Inputs seen one cycle back
   logic        prev_marker = 1'b0;
   logic        prev_strobe = 1'b0;
   logic        prev_done   = 1'b0;
   logic        prev_en     = 1'b0;
   logic        done_seen   = 1'b0;                     // Rise already seen this window
   int          word_idx    = -1;                       // Model word index from reset release
   int          en_cnt      = 0;                        // Cycles since enable rose
   int          cur_sum     = 0;                        // Expected wait of the current row
   int          err_cnt     = 0;
   int          check_cnt   = 0;
   int          rows_failed = 0;
   int          row_start;
   int          cycle_cnt   = 0;
   int          cycle_limit = 0;

   aib_leader_ca_top aib_leader_ca_top_inst
   (
      .m_wr_clk            (m_wr_clk),
      .m_wr_rst_n          (m_wr_rst_n),
      .i_delay_x_value     (i_delay_x_value),
      .i_delay_z_value     (i_delay_z_value),
      .i_sl_tx_transfer_en (i_sl_tx_transfer_en),
      .i_ms_tx_transfer_en (i_ms_tx_transfer_en),
      .i_ll2ca             (i_ll2ca),
      .o_ca2phy            (o_ca2phy),
      .o_tx_transfer_en    (o_tx_transfer_en),
      .o_align_done        (o_align_done)
   );

   initial
   begin
      m_wr_clk = 1'b0;
      forever #2 m_wr_clk = ~m_wr_clk;                  // 4 ns period
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];                 // Taps 32 22 2 1
      return {s[30:0], fb};
   endfunction

   task automatic random_lanes(output lane_bus_t lanes);
      logic [NUM_CHANNELS*LANE_BITS-1:0] flat;
      for (int b = 0; b < NUM_CHANNELS*LANE_BITS; b++)
      begin
         lfsr_state = lfsr_step(lfsr_state);            // One step per bit
         flat[b]    = lfsr_state[0];
      end
      lanes = flat;
   endtask

   task automatic add_row(input logic [DELAY_IN_W-1:0] x, input logic [DELAY_IN_W-1:0] z,
                          input chan_mask_t sl, input chan_mask_t ms, input int len);
      tbl_x.push_back(x);
      tbl_z.push_back(z);
      tbl_sl.push_back(sl);
      tbl_ms.push_back(ms);
      tbl_len.push_back(len);
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %0b actual %0b", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic compare_lane_bus(input string name, input lane_bus_t exp,
                                   input lane_bus_t act);
      check_cnt++;
      if (act !== exp)
      begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // ------------------------------
   // Per cycle checks at negedge
   // ------------------------------
   task automatic check_cycle();
      lane_bus_t exp_bus;
      logic      exp_en;
      word_idx++;
      exp_en = (i_sl_tx_transfer_en == '1) && (i_ms_tx_transfer_en == '1);
      compare_bit("o_tx_transfer_en", exp_en, o_tx_transfer_en);
      exp_bus = '0;                                     // Idle lanes unless aligned
      if (prev_done)
      begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++)
         begin
            exp_bus[ch].raw             = prev_ll2ca[ch].raw;
            exp_bus[ch].raw[MARKER_LOC] = prev_marker;
            exp_bus[ch].raw[STROBE_LOC] = prev_strobe;
         end
      end
      compare_lane_bus("o_ca2phy", exp_bus, o_ca2phy);
      if (exp_en)
         en_cnt = prev_en ? en_cnt + 1 : 0;
      if (!prev_en)
      begin
         compare_bit("o_align_done", 1'b0, o_align_done); // Low one cycle after a drop
         done_seen = 1'b0;
      end
      else if (exp_en)
      begin
         if (o_align_done && !done_seen)
         begin
            done_seen = 1'b1;
            if (en_cnt < cur_sum)
            begin
               $display("Alignment done rose after %0d cycles, earlier than the wait of %0d",
                        en_cnt, cur_sum);
               err_cnt++;
            end
         end
         else if (!o_align_done && done_seen)
            compare_bit("o_align_done", 1'b1, o_align_done); // Must hold while enabled
         else if (!o_align_done && en_cnt == cur_sum + 4)
         begin
            $display("Alignment done never rose within %0d to %0d cycles of the enable",
                     cur_sum, cur_sum + 4);
            err_cnt++;
         end
      end
      else if (done_seen)
         compare_bit("o_align_done", 1'b1, o_align_done); // Still high on the drop cycle
      prev_ll2ca  = i_ll2ca;                            // Sampled by the DUT at next edge
      prev_marker = (word_idx % WORDS_PER_MARKER) == WORDS_PER_MARKER - 1;
      prev_strobe = (word_idx % STB_INTV_WORDS) == STB_INTV_WORDS - 1;
      prev_done   = o_align_done;
      prev_en     = exp_en;
   endtask

   // Run limit from the table length
   always @(posedge m_wr_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
      begin
         $display("Timeout: run passed %0d cycles without finishing", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin
      m_wr_rst_n          = 1'b0;
      i_delay_x_value     = '0;
      i_delay_z_value     = '0;
      i_sl_tx_transfer_en = '0;
      i_ms_tx_transfer_en = '0;
      i_ll2ca             = '0;
      // Delays change only while disabled so the wait window stays exact
      add_row(32'd4, 32'd6, 7'h00, 7'h00, 6);
      add_row(32'd4, 32'd6, 7'h7f, 7'h7f, 24);
      add_row(32'd4, 32'd6, 7'h7f, 7'h3f, 5);           // Partial mask drops done
      add_row(32'd4, 32'd6, 7'h7f, 7'h7f, 20);
      add_row(32'h0001_0003, 32'habcd_0005, 7'h5e, 7'h7f, 6); // Upper halves ignored
      add_row(32'h0001_0003, 32'habcd_0005, 7'h7f, 7'h7f, 70); // Covers a strobe
      add_row(32'd0, 32'd0, 7'h00, 7'h7f, 5);
      add_row(32'd0, 32'd0, 7'h7f, 7'h7f, 12);          // Zero wait
      add_row(32'd20, 32'd12, 7'h7f, 7'h7e, 6);
      add_row(32'd20, 32'd12, 7'h7f, 7'h7f, 60);
      add_row(32'd20, 32'd12, 7'h00, 7'h00, 4);
      cycle_limit = 8 + 64;
      foreach (tbl_len[r])
         cycle_limit += tbl_len[r];
      repeat (8) @(posedge m_wr_clk);
      m_wr_rst_n <= 1'b1;
      @(negedge m_wr_clk);
      row_start = err_cnt;
      check_cycle();                                    // Reset state, word index 0
      $display("Reset state: %s", (err_cnt == row_start) ? "pass" : "fail");
      if (err_cnt != row_start)
         rows_failed++;
      foreach (tbl_len[r])
      begin
         row_start = err_cnt;
         cur_sum   = int'(tbl_x[r][15:0]) / int'(LEADER_RATE) +
                     int'(tbl_z[r][15:0]) / int'(LEADER_RATE);
         for (int k = 0; k < tbl_len[r]; k++)
         begin
            @(posedge m_wr_clk);
            random_lanes(next_lanes);
            i_delay_x_value     <= tbl_x[r];
            i_delay_z_value     <= tbl_z[r];
            i_sl_tx_transfer_en <= tbl_sl[r];
            i_ms_tx_transfer_en <= tbl_ms[r];
            i_ll2ca             <= next_lanes;
            @(negedge m_wr_clk);
            check_cycle();
         end
         $display("Row %0d masks %h %h wait %0d: %s", r, tbl_sl[r], tbl_ms[r], cur_sum,
                  (err_cnt == row_start) ? "pass" : "fail");
         if (err_cnt != row_start)
            rows_failed++;
      end
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tbl_len.size() + 1, rows_failed, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: aib_leader_ca.f
source/aib_rate_pkg.sv
source/ca_word_pkg.sv
source/align_timer.sv
source/marker_strobe_gen.sv
source/ca_tx_framer.sv
source/aib_leader_ca_top.sv
tests/aib_leader_ca_tb.sv
